/* src/nx_pkg.sv */
/*
 * Shared sizes, instruction layout and enums for one evaluation node.
 * Sizes are fixed here and the modules carry no parameters.
 * Source selects address both the input vector and the working registers,
 * so NX_INPUTS and NX_REGISTERS must both equal 2**NX_SRC_W.
 */
package nx_pkg;

    // Node sizes
    localparam int NX_INPUTS     = 8;  // Input vector width
    localparam int NX_OUTPUTS    = 8;  // Output vector width
    localparam int NX_REGISTERS  = 8;  // Working registers
    localparam int NX_MAX_INSTRS = 64; // Store depth
    localparam int NX_ADDR_W     = 6;  // Instruction address
    localparam int NX_OUT_IDX_W  = 3;  // Output slot index
    localparam int NX_SRC_W      = 3;  // Source or target select
    localparam int NX_OP_W       = 3;  // Opcode
    localparam int NX_INSTR_W    = 15; // Whole instruction

    // Field positions, MSB first
    localparam int NX_OP_LSB      = 12; // [14:12] opcode
    localparam int NX_SRC_A_LSB   = 9;  // [11:9]  source A select
    localparam int NX_SRC_A_IP    = 8;  // Source A taken from inputs
    localparam int NX_SRC_B_LSB   = 5;  // [7:5]   source B select
    localparam int NX_SRC_B_IP    = 4;  // Source B taken from inputs
    localparam int NX_TGT_LSB     = 1;  // [3:1]   target register
    localparam int NX_GEN_OUT     = 0;  // Write next output slot

    // Gate operations
    typedef enum logic [NX_OP_W-1:0] {
          OP_INVERT // !A
        , OP_AND    //   A & B
        , OP_NAND   // !(A & B)
        , OP_OR     //   A | B
        , OP_NOR    // !(A | B)
        , OP_XOR    //   A ^ B
        , OP_XNOR   // !(A ^ B)
        , OP_UNUSED // Always 0
    } nx_op_e;

    // Fetch and execute stage state
    typedef enum logic {
          PH_IDLE
        , PH_ACTIVE
    } nx_phase_e;

endpackage : nx_pkg

/* src/nx_fetch_if.sv */
/*
 * Fetch path between core and instruction store.
 * A read with instr_stall low is accepted and its word shows up one cycle
 * later. During a stall the store repeats its last word.
 */
`timescale 1ns/1ps

interface nx_fetch_if;

    logic [nx_pkg::NX_ADDR_W-1:0]  instr_addr;  // Fetch address
    logic                          instr_rd;    // Read strobe
    logic [nx_pkg::NX_INSTR_W-1:0] instr_data;  // Word read last cycle
    logic                          instr_stall; // Port busy with host write

    // Core side issues reads
    modport core (
          output instr_addr
        , output instr_rd
        , input  instr_data
        , input  instr_stall
    );

    // Store side answers them
    modport store (
          input  instr_addr
        , input  instr_rd
        , output instr_data
        , output instr_stall
    );

endinterface : nx_fetch_if

/* src/nx_instr_store.sv */
/*
 * Single-port instruction memory, loaded by the host while the node runs.
 * A host write owns the port for its cycle and stalls fetch.
 * Read latency is one cycle. Memory contents have no reset.
 */
`timescale 1ns/1ps

module nx_instr_store (
      input  logic                          clk_i
    , input  logic                          rst_n_i
    // Host load port
    , input  logic                          load_en_i   // Write strobe
    , input  logic [nx_pkg::NX_ADDR_W-1:0]  load_addr_i // Write address
    , input  logic [nx_pkg::NX_INSTR_W-1:0] load_data_i // Instruction word
    // Fetch from core
    , nx_fetch_if.store                     fetch
);

    // Storage
    logic [nx_pkg::NX_INSTR_W-1:0] mem_q [nx_pkg::NX_MAX_INSTRS];

    // Single shared port
    logic [nx_pkg::NX_ADDR_W-1:0]  port_addr;
    logic                          port_rd;
    logic [nx_pkg::NX_INSTR_W-1:0] rd_data_q;

    // Host write wins the port
    assign port_addr = load_en_i ? load_addr_i : fetch.instr_addr;
    assign port_rd   = fetch.instr_rd && !load_en_i; // Read refused on write

    // Tell the core its read was not taken
    assign fetch.instr_stall = load_en_i;
    assign fetch.instr_data  = rd_data_q;

    // Write side
    always_ff @(posedge clk_i) begin : p_write
        if (load_en_i) begin
            mem_q[port_addr] <= load_data_i;
        end
    end

    // Registered read, held when no read is accepted
    always_ff @(posedge clk_i) begin : p_read
        if (!rst_n_i) begin
            rd_data_q <= '0;
        end else if (port_rd) begin
            rd_data_q <= mem_q[port_addr]; // Valid next cycle
        end
    end

endmodule : nx_instr_store

/* src/nx_node_core.sv */
/*
 * Two stage gate evaluator. Fetch steps pc from 0 to populated_i and execute
 * runs one cycle behind it. A trigger aborts any run, even during a stall,
 * and clears the working registers and the output slot index.
 * Output slots not written in a run keep their earlier values.
 */
`timescale 1ns/1ps

module nx_node_core (
      input  logic                          clk_i
    , input  logic                          rst_n_i
    // Simulated logic I/O
    , input  logic [nx_pkg::NX_INPUTS-1:0]  inputs_i    // Copy held for the run
    , output logic [nx_pkg::NX_OUTPUTS-1:0] outputs_o   // Output slots
    // Run control
    , input  logic [nx_pkg::NX_ADDR_W-1:0]  populated_i // Program length
    , input  logic                          trigger_i   // Start or restart
    , output logic                          idle_o      // No run in progress
    // Instruction fetch
    , nx_fetch_if.core                      fetch
);

    // Stage state
    nx_pkg::nx_phase_e fetch_state_q, fetch_state_d;
    nx_pkg::nx_phase_e exec_state_q, exec_state_d;

    logic [nx_pkg::NX_ADDR_W-1:0]    pc_q, pc_d;
    logic [nx_pkg::NX_REGISTERS-1:0] working_q, working_d;
    logic [nx_pkg::NX_OUTPUTS-1:0]   outputs_q, outputs_d;
    logic [nx_pkg::NX_OUT_IDX_W-1:0] out_idx_q, out_idx_d;

    logic fetch_rd; // Read issued this cycle

    // Reads stop once every populated word has been asked for
    assign fetch_rd = (fetch_state_q == nx_pkg::PH_ACTIVE) && (pc_q < populated_i);

    assign fetch.instr_addr = pc_q;
    assign fetch.instr_rd   = fetch_rd;
    assign outputs_o        = outputs_q;
    assign idle_o           = (fetch_state_q == nx_pkg::PH_IDLE)
                           && (exec_state_q == nx_pkg::PH_IDLE);

    // Fetch stage
    always_comb begin : p_fetch
        fetch_state_d = fetch_state_q;
        pc_d          = pc_q;

        if (trigger_i) begin // Restart from 0, stall or not
            fetch_state_d = nx_pkg::PH_ACTIVE;
            pc_d          = '0;
        end else if (fetch_state_q == nx_pkg::PH_ACTIVE && !fetch.instr_stall) begin
            if (fetch_rd) begin
                pc_d = pc_q + 1'b1; // Read accepted
            end else begin
                fetch_state_d = nx_pkg::PH_IDLE; // All words issued
            end
        end
    end

    // Execute stage
    always_comb begin : p_execute
        nx_pkg::nx_op_e                opcode;
        logic [nx_pkg::NX_SRC_W-1:0]   src_a;
        logic [nx_pkg::NX_SRC_W-1:0]   src_b;
        logic [nx_pkg::NX_SRC_W-1:0]   tgt_reg;
        logic                          ip_a;
        logic                          ip_b;
        logic                          gen_out;
        logic                          val_a;
        logic                          val_b;
        logic                          result;

        exec_state_d = exec_state_q;
        working_d    = working_q;
        outputs_d    = outputs_q;
        out_idx_d    = out_idx_q;

        // Field decode
        opcode  = nx_pkg::nx_op_e'(fetch.instr_data[nx_pkg::NX_OP_LSB +: nx_pkg::NX_OP_W]);
        src_a   = fetch.instr_data[nx_pkg::NX_SRC_A_LSB +: nx_pkg::NX_SRC_W];
        ip_a    = fetch.instr_data[nx_pkg::NX_SRC_A_IP];
        src_b   = fetch.instr_data[nx_pkg::NX_SRC_B_LSB +: nx_pkg::NX_SRC_W];
        ip_b    = fetch.instr_data[nx_pkg::NX_SRC_B_IP];
        tgt_reg = fetch.instr_data[nx_pkg::NX_TGT_LSB +: nx_pkg::NX_SRC_W];
        gen_out = fetch.instr_data[nx_pkg::NX_GEN_OUT];

        // Operand pickup
        val_a = ip_a ? inputs_i[src_a] : working_q[src_a];
        val_b = ip_b ? inputs_i[src_b] : working_q[src_b];

        case (opcode)
            nx_pkg::OP_INVERT: result = !val_a;
            nx_pkg::OP_AND:    result = val_a & val_b;
            nx_pkg::OP_NAND:   result = !(val_a & val_b);
            nx_pkg::OP_OR:     result = val_a | val_b;
            nx_pkg::OP_NOR:    result = !(val_a | val_b);
            nx_pkg::OP_XOR:    result = val_a ^ val_b;
            nx_pkg::OP_XNOR:   result = !(val_a ^ val_b);
            default:           result = 1'b0; // OP_UNUSED
        endcase

        if (trigger_i) begin
            // Abort and start the new run from a clean state
            exec_state_d = nx_pkg::PH_IDLE;
            working_d    = '0;
            out_idx_d    = '0;
        end else if (!fetch.instr_stall) begin
            if (exec_state_q == nx_pkg::PH_ACTIVE) begin
                working_d[tgt_reg] = result;
                if (gen_out) begin
                    outputs_d[out_idx_q] = result;
                    out_idx_d            = out_idx_q + 1'b1; // Next slot
                end
            end
            // Word arrives next cycle only if a read went out now
            exec_state_d = fetch_rd ? nx_pkg::PH_ACTIVE : nx_pkg::PH_IDLE;
        end
    end

    always_ff @(posedge clk_i) begin : p_state
        if (!rst_n_i) begin
            fetch_state_q <= nx_pkg::PH_IDLE;
            exec_state_q  <= nx_pkg::PH_IDLE;
            pc_q          <= '0;
            working_q     <= '0;
            outputs_q     <= '0;
            out_idx_q     <= '0;
        end else begin
            fetch_state_q <= fetch_state_d;
            exec_state_q  <= exec_state_d;
            pc_q          <= pc_d;
            working_q     <= working_d;
            outputs_q     <= outputs_d;
            out_idx_q     <= out_idx_d;
        end
    end

endmodule : nx_node_core

/* src/nx_node_ctrl.sv */
/*
 * Run trigger for the node. An input change or a run_i pulse gives one
 * trigger cycle later, together with a frozen copy of the inputs.
 * A run request that lands while a trigger is still waiting on an idle
 * core with unchanged inputs is folded into that trigger.
 */
`timescale 1ns/1ps

module nx_node_ctrl (
      input  logic                         clk_i
    , input  logic                         rst_n_i
    , input  logic [nx_pkg::NX_INPUTS-1:0] inputs_i      // Live inputs
    , input  logic                         run_i         // Host run request
    , input  logic                         core_idle_i   // Core not running
    , output logic                         trigger_o     // One cycle start pulse
    , output logic [nx_pkg::NX_INPUTS-1:0] held_inputs_o // Inputs for the run
);

    logic [nx_pkg::NX_INPUTS-1:0] sample_q; // Previous sample
    logic [nx_pkg::NX_INPUTS-1:0] held_q;
    logic                         trigger_q;

    logic changed;   // Inputs moved since last edge
    logic redundant; // Pending trigger already covers it
    logic request;

    assign changed = (inputs_i != sample_q);

    // Core has not left idle yet for the trigger in flight
    assign redundant = trigger_q && core_idle_i && !changed;
    assign request   = (changed || run_i) && !redundant;

    assign trigger_o     = trigger_q;
    assign held_inputs_o = held_q;

    always_ff @(posedge clk_i) begin : p_detect
        if (!rst_n_i) begin
            sample_q  <= '0;
            trigger_q <= 1'b0;
        end else begin
            sample_q  <= inputs_i;
            trigger_q <= request; // Single pulse per request
        end
    end

    // Frozen until the next trigger
    always_ff @(posedge clk_i) begin : p_hold
        if (request) begin
            held_q <= inputs_i;
        end
    end

endmodule : nx_node_ctrl

/* src/nx_node.sv */
/*
 * Single evaluation node. Program words are loaded through load_* at any
 * time, and a write stalls fetch for its cycle.
 * End of run is the rising edge of idle_o.
 */
`timescale 1ns/1ps

module nx_node (
      input  logic                          clk_i
    , input  logic                          rst_n_i
    // Simulated logic I/O
    , input  logic [nx_pkg::NX_INPUTS-1:0]  inputs_i
    , output logic [nx_pkg::NX_OUTPUTS-1:0] outputs_o
    // Run control
    , input  logic                          run_i       // Host run strobe
    , input  logic [nx_pkg::NX_ADDR_W-1:0]  populated_i // Program length
    , output logic                          idle_o
    // Program load
    , input  logic                          load_en_i
    , input  logic [nx_pkg::NX_ADDR_W-1:0]  load_addr_i
    , input  logic [nx_pkg::NX_INSTR_W-1:0] load_data_i
);

    logic                         trigger;
    logic [nx_pkg::NX_INPUTS-1:0] held_inputs; // Inputs frozen per run

    nx_fetch_if i_fetch ();

    nx_node_ctrl i_ctrl (
          .clk_i         (clk_i)
        , .rst_n_i       (rst_n_i)
        , .inputs_i      (inputs_i)
        , .run_i         (run_i)
        , .core_idle_i   (idle_o)
        , .trigger_o     (trigger)
        , .held_inputs_o (held_inputs)
    );

    nx_instr_store i_store (
          .clk_i       (clk_i)
        , .rst_n_i     (rst_n_i)
        , .load_en_i   (load_en_i)
        , .load_addr_i (load_addr_i)
        , .load_data_i (load_data_i)
        , .fetch       (i_fetch.store)
    );

    nx_node_core i_core (
          .clk_i       (clk_i)
        , .rst_n_i     (rst_n_i)
        , .inputs_i    (held_inputs) // Never the live inputs
        , .outputs_o   (outputs_o)
        , .populated_i (populated_i)
        , .trigger_i   (trigger)
        , .idle_o      (idle_o)
        , .fetch       (i_fetch.core)
    );

endmodule : nx_node

/* dv/nx_clk_gen.sv */
/*
 * Testbench clock of 20 ns period and an active low reset.
 * Reset is released on a rising edge after 5 cycles.
 */
`timescale 1ns/1ps

module nx_clk_gen (
      output logic clk_o
    , output logic rst_n_o
);

    initial begin : p_clock
        clk_o = 1'b0;
        forever #10 clk_o = ~clk_o; // 20 ns period
    end

    initial begin : p_reset
        rst_n_o = 1'b0;
        repeat (5) @(posedge clk_o);
        rst_n_o <= 1'b1; // Synchronous release
    end

endmodule : nx_clk_gen

/* dv/nx_node_checker.sv */
/*
 * Scoreboard for nx_node. Mirrors the program from the load port and
 * evaluates it at every rising edge of idle_o. An end of run that a pending
 * restart will overwrite is skipped. Loads below populated_i during a run
 * are not modelled.
 */
`timescale 1ns/1ps

module nx_node_checker (
      input  logic                          clk_i
    , input  logic                          rst_n_i
    , input  logic [nx_pkg::NX_INPUTS-1:0]  inputs_i
    , input  logic                          run_i
    , input  logic [nx_pkg::NX_ADDR_W-1:0]  populated_i
    , input  logic                          load_en_i
    , input  logic [nx_pkg::NX_ADDR_W-1:0]  load_addr_i
    , input  logic [nx_pkg::NX_INSTR_W-1:0] load_data_i
    , input  logic [nx_pkg::NX_OUTPUTS-1:0] outputs_i
    , input  logic                          idle_i
    , output int                            check_count_o
    , output int                            error_count_o
);

    logic [nx_pkg::NX_INSTR_W-1:0] prog_q [nx_pkg::NX_MAX_INSTRS]; // Program mirror
    logic [nx_pkg::NX_INPUTS-1:0]  sample_q;     // Inputs at the last edge
    logic [nx_pkg::NX_INPUTS-1:0]  run_inputs_q; // Inputs of the latest request
    logic [nx_pkg::NX_OUTPUTS-1:0] model_out_q;  // Slots as the model sees them
    logic                          idle_last_q;
    logic                          req_last_q;

    // One gate as the opcode table defines it
    function automatic logic gate_value(input nx_pkg::nx_op_e op, input logic a,
                                        input logic b);
        case (op)
            nx_pkg::OP_INVERT: return !a;
            nx_pkg::OP_AND:    return a && b;
            nx_pkg::OP_NAND:   return !(a && b);
            nx_pkg::OP_OR:     return a || b;
            nx_pkg::OP_NOR:    return !(a || b);
            nx_pkg::OP_XOR:    return a != b;
            nx_pkg::OP_XNOR:   return a == b;
            default:           return 1'b0;
        endcase
    endfunction

    // Whole program from cleared registers, slots filled in order
    function automatic logic [nx_pkg::NX_OUTPUTS-1:0] run_program(
            input logic [nx_pkg::NX_INPUTS-1:0]  ins,
            input logic [nx_pkg::NX_ADDR_W-1:0]  len,
            input logic [nx_pkg::NX_OUTPUTS-1:0] start_out);
        logic [nx_pkg::NX_REGISTERS-1:0] regs;
        logic [nx_pkg::NX_OUTPUTS-1:0]   outs;
        logic [nx_pkg::NX_OUT_IDX_W-1:0] slot;
        logic [nx_pkg::NX_INSTR_W-1:0]   w;
        logic                            a;
        logic                            b;
        logic                            r;
        int                              idx;

        regs = '0;
        outs = start_out; // Untouched slots keep old values
        slot = '0;
        for (idx = 0; idx < int'(len); idx++) begin
            w = prog_q[idx];
            a = w[nx_pkg::NX_SRC_A_IP] ? ins[w[nx_pkg::NX_SRC_A_LSB +: nx_pkg::NX_SRC_W]]
                                       : regs[w[nx_pkg::NX_SRC_A_LSB +: nx_pkg::NX_SRC_W]];
            b = w[nx_pkg::NX_SRC_B_IP] ? ins[w[nx_pkg::NX_SRC_B_LSB +: nx_pkg::NX_SRC_W]]
                                       : regs[w[nx_pkg::NX_SRC_B_LSB +: nx_pkg::NX_SRC_W]];
            r = gate_value(nx_pkg::nx_op_e'(w[nx_pkg::NX_OP_LSB +: nx_pkg::NX_OP_W]), a, b);
            regs[w[nx_pkg::NX_TGT_LSB +: nx_pkg::NX_SRC_W]] = r;
            if (w[nx_pkg::NX_GEN_OUT]) begin
                outs[slot] = r;
                slot       = slot + 3'd1; // Wraps after the last slot
            end
        end
        return outs;
    endfunction

    always_ff @(posedge clk_i) begin : p_check
        logic                          req_now;
        logic [nx_pkg::NX_OUTPUTS-1:0] expected;

        req_now = (inputs_i != sample_q) || run_i; // Same rule as the node control
        if (!rst_n_i) begin
            sample_q      <= '0;
            model_out_q   <= '0;
            idle_last_q   <= 1'b1;
            req_last_q    <= 1'b0;
            check_count_o <= 0;
            error_count_o <= 0;
        end else begin
            sample_q    <= inputs_i;
            idle_last_q <= idle_i;
            req_last_q  <= req_now;
            if (req_now) begin
                run_inputs_q <= inputs_i;
            end
            if (load_en_i) begin
                prog_q[load_addr_i] <= load_data_i;
            end
            // Rising idle with no restart in flight
            if (idle_i && !idle_last_q && !req_now && !req_last_q) begin
                expected      = run_program(run_inputs_q, populated_i, model_out_q);
                model_out_q   <= expected;
                check_count_o <= check_count_o + 1;
                if (outputs_i !== expected) begin
                    error_count_o <= error_count_o + 1;
                    $display("FAIL %0t ns: outputs_o %b, expected %b (inputs %b, length %0d)",
                             $time, outputs_i, expected, run_inputs_q, populated_i);
                end
            end
        end
    end

endmodule : nx_node_checker

/* dv/nx_node_props.sv */
/*
 * Fetch and run control properties of the node core, bound to every
 * nx_node_core instance. A trigger during a stall may move pc.
 */
`timescale 1ns/1ps

module nx_node_props (
      input logic                         clk_i
    , input logic                         rst_n_i
    , input logic                         idle_i
    , input logic                         instr_rd_i
    , input logic                         instr_stall_i
    , input logic                         trigger_i
    , input logic [nx_pkg::NX_ADDR_W-1:0] pc_i
);

    // No fetch strobe outside a run
    a_no_read_when_idle : assert property (@(posedge clk_i) disable iff (!rst_n_i)
        idle_i |-> !instr_rd_i)
        else $error("Fetch read strobe high while the core is idle");

    a_pc_holds_on_stall : assert property (@(posedge clk_i) disable iff (!rst_n_i)
        instr_stall_i && !trigger_i |=> pc_i == $past(pc_i))
        else $error("Program counter moved during a fetch stall");

    // Run starts one cycle after its trigger
    a_trigger_leaves_idle : assert property (@(posedge clk_i) disable iff (!rst_n_i)
        trigger_i |=> !idle_i)
        else $error("Core stayed idle after a trigger");

endmodule : nx_node_props

bind nx_node_core nx_node_props i_props (
      .clk_i         (clk_i)
    , .rst_n_i       (rst_n_i)
    , .idle_i        (idle_o)
    , .instr_rd_i    (fetch.instr_rd)
    , .instr_stall_i (fetch.instr_stall)
    , .trigger_i     (trigger_i)
    , .pc_i          (pc_q)
);

/* dv/tb_nx_node.sv */
/*
 * Top testbench for nx_node. Random programs, input changes, restarts and
 * host writes beyond the program, all from one fixed LFSR seed.
 * Each wait on idle_o is a bounded loop.
 */
`timescale 1ns/1ps

module tb_nx_node;

    logic                          clk;
    logic                          rst_n;
    logic [nx_pkg::NX_INPUTS-1:0]  node_inputs;
    logic                          run;
    logic [nx_pkg::NX_ADDR_W-1:0]  populated;
    logic                          load_en;
    logic [nx_pkg::NX_ADDR_W-1:0]  load_addr;
    logic [nx_pkg::NX_INSTR_W-1:0] load_data;
    logic [nx_pkg::NX_OUTPUTS-1:0] node_outputs;
    logic                          idle;
    int                            check_count;
    int                            error_count;
    int                            timeout_count;
    logic [31:0]                   lfsr_q;

    nx_clk_gen i_clk_gen (.clk_o(clk), .rst_n_o(rst_n));

    nx_node i_dut (
          .clk_i (clk), .rst_n_i (rst_n)
        , .inputs_i (node_inputs), .outputs_o (node_outputs)
        , .run_i (run), .populated_i (populated), .idle_o (idle)
        , .load_en_i (load_en), .load_addr_i (load_addr), .load_data_i (load_data)
    );

    nx_node_checker i_checker (
          .clk_i (clk), .rst_n_i (rst_n), .inputs_i (node_inputs), .run_i (run)
        , .populated_i (populated), .load_en_i (load_en), .load_addr_i (load_addr)
        , .load_data_i (load_data), .outputs_i (node_outputs), .idle_i (idle)
        , .check_count_o (check_count), .error_count_o (error_count)
    );

    // Galois LFSR, one step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] val;
        val = '0;
        repeat (n) begin
            lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 32'hA300_0000) : (lfsr_q >> 1);
            val    = {val[30:0], lfsr_q[0]};
        end
        return val;
    endfunction

    function automatic logic [nx_pkg::NX_INSTR_W-1:0] random_word(input int idx,
            input bit cover_ops, input bit sparse);
        logic [31:0]                   r;
        logic [nx_pkg::NX_INSTR_W-1:0] w;
        r = rand_bits(nx_pkg::NX_INSTR_W);
        w = r[nx_pkg::NX_INSTR_W-1:0];
        if (cover_ops) begin
            w[nx_pkg::NX_OP_LSB +: nx_pkg::NX_OP_W] = idx[2:0]; // Every opcode in turn
        end
        if (sparse) begin
            r = rand_bits(2);
            w[nx_pkg::NX_GEN_OUT] = (r[1:0] == 2'd0); // Few outputs
        end
        return w;
    endfunction

    task automatic load_program(input int len, input bit cover_ops, input bit sparse);
        for (int i = 0; i < len; i++) begin
            @(posedge clk);
            load_en   <= 1'b1;
            load_addr <= i[nx_pkg::NX_ADDR_W-1:0];
            load_data <= random_word(i, cover_ops, sparse);
        end
        @(posedge clk);
        load_en <= 1'b0;
    endtask

    task automatic set_length(input int len);
        @(posedge clk);
        populated <= len[nx_pkg::NX_ADDR_W-1:0];
    endtask

    task automatic pulse_run();
        @(posedge clk);
        run <= 1'b1;
        @(posedge clk);
        run <= 1'b0;
    endtask

    task automatic change_inputs();
        logic [31:0] r;
        r = rand_bits(nx_pkg::NX_INPUTS);
        if (r[7:0] == node_inputs) begin
            r[0] = !r[0]; // Must differ to count as a change
        end
        @(posedge clk);
        node_inputs <= r[7:0];
    endtask

    // Host writes at or above populated, each one stalls fetch
    task automatic write_beyond_program(input int cycles);
        logic [31:0] r;
        int          span;
        span = nx_pkg::NX_MAX_INSTRS - int'(populated);
        repeat (cycles) begin
            @(posedge clk);
            r = rand_bits(7);
            load_en   <= r[6];
            load_addr <= 6'(int'(populated) + int'(r[5:0]) % span);
            load_data <= 15'(rand_bits(nx_pkg::NX_INSTR_W));
        end
        @(posedge clk);
        load_en <= 1'b0;
    endtask

    // Run must start, then idle_o must rise again
    task automatic wait_run_end();
        int waited;
        waited = 0;
        while (idle && waited < 10) begin
            @(negedge clk);
            waited++;
        end
        if (idle) begin
            timeout_count++;
            $display("Timeout at %0t ns: the node never left idle", $time);
        end
        waited = 0;
        while (!idle && waited < 400) begin
            @(negedge clk);
            waited++;
        end
        if (!idle) begin
            timeout_count++;
            $display("Timeout at %0t ns: the run did not finish", $time);
        end
    endtask

    initial begin : p_main
        int len;
        int waited;
        lfsr_q        = 32'h8db0_16aa;
        timeout_count = 0;
        node_inputs   = '0;
        run           = 1'b0;
        populated     = '0;
        load_en       = 1'b0;
        load_addr     = '0;
        load_data     = '0;
        waited        = 0;
        while (!rst_n && waited < 20) begin
            @(negedge clk);
            waited++;
        end
        if (!rst_n) begin
            timeout_count++;
            $display("Timeout: reset was never released");
        end

        for (int round = 0; round < 12; round++) begin
            len = 16 + int'(rand_bits(5)); // 16 to 47 words
            load_program(len, round == 0, 1'b0);
            set_length(len);
            pulse_run();
            wait_run_end();
            change_inputs(); // Idle change starts a run by itself
            wait_run_end();
            pulse_run();     // Restart somewhere inside the run
            repeat (int'(rand_bits(5)) % len) @(posedge clk);
            if (rand_bits(1) != 0) change_inputs();
            else pulse_run();
            wait_run_end();
            pulse_run();
            write_beyond_program(6);
            wait_run_end();
        end

        // Empty program, then one with few outputs
        set_length(0);
        pulse_run();
        wait_run_end();
        change_inputs();
        wait_run_end();
        load_program(5, 1'b0, 1'b1);
        set_length(5);
        pulse_run();
        wait_run_end();
        repeat (4) @(posedge clk);

        if (check_count == 0) begin
            $display("No node result was ever compared");
        end
        $display("Checks %0d, value errors %0d, timeouts %0d",
                 check_count, error_count, timeout_count);
        if (error_count == 0 && timeout_count == 0 && check_count > 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule : tb_nx_node

/* nx_node.f */
src/nx_pkg.sv
src/nx_fetch_if.sv
src/nx_instr_store.sv
src/nx_node_core.sv
src/nx_node_ctrl.sv
src/nx_node.sv
dv/nx_clk_gen.sv
dv/nx_node_checker.sv
dv/nx_node_props.sv
dv/tb_nx_node.sv

/* run.sh */
#!/bin/sh
# Build and run the nx_node testbench with Verilator.
# Exit status is 0 only when the pass message shows up in the simulation output.

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal -f nx_node.f \
        --top-module tb_nx_node -o sim_nx_node; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/sim_nx_node)
status=$?
printf '%s\n' "$output"

if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx 'Finished with no errors'; then
    exit 0
fi
exit 1
